// File: logic/traffic_gen_pkg.sv
`default_nettype none

package traffic_gen_pkg;

  // --------------------------------------------------------------------------
  // Ethernet and ARP framing
  // --------------------------------------------------------------------------
  localparam logic [7:0]  preamble_byte  = 8'h55;
  localparam logic [7:0]  sfd_byte       = 8'hd5;       // 0b1101_0101
  localparam int unsigned preamble_len   = 8;           // Seven preamble bytes plus SFD
  localparam int unsigned fcs_len        = 4;
  localparam logic [15:0] ethertype_ipv4 = 16'h0800;
  localparam logic [15:0] ethertype_arp  = 16'h0806;
  localparam logic [15:0] arp_op_request = 16'h0001;
  localparam logic [15:0] arp_op_reply   = 16'h0002;

  // --------------------------------------------------------------------------
  // IPv4/UDP test frame
  // --------------------------------------------------------------------------
  localparam logic [7:0]  ipv4_ttl        = 8'd64;
  localparam logic [15:0] udp_port        = 16'd3422;
  localparam logic [39:0] magic_code      = 40'hcc00cc00cc;
  localparam int unsigned arp_frame_len   = 64;         // Padded to 60, then FCS
  localparam int unsigned min_gap         = 2;
  localparam int unsigned ip_hdr_overhead = 18;         // Ethernet header and FCS
  localparam int unsigned udp_overhead    = 38;         // Same plus 20 byte IPv4 header

  // Received ARP fields, counted from the dest MAC
  localparam int unsigned rx_off_type   = 12;
  localparam int unsigned rx_off_opcode = 20;
  localparam int unsigned rx_off_sha    = 22;           // Sender MAC
  localparam int unsigned rx_off_spa    = 28;           // Sender IP
  localparam int unsigned rx_off_tpa    = 38;           // Target IP
  localparam int unsigned rx_off_end    = 42;

  typedef logic [47:0] mac_t;
  typedef logic [31:0] ip4_t;

  typedef struct packed {
    logic [7:0] data;
    logic       en;
  } gmii_t;

  typedef struct packed {
    logic        enable;
    mac_t        src_mac;
    ip4_t        src_ip;
    ip4_t        gw_ip;
    ip4_t        dst_ip;
    logic [15:0] frame_len;                             // Dest MAC through FCS
    logic [31:0] gap;                                   // Idle cycles between frames
  } tx_config_t;

  typedef enum logic [1:0] {
    req_arp,
    wait_arp,
    send_v4,
    gap
  } tx_state_e;

endpackage

`default_nettype wire

// File: logic/crc32_gen.sv
`timescale 1ns/1ps
`default_nettype none

module crc32_gen (
  input  logic        gmii_tx_clk,
  input  logic        sys_rst,
  input  logic        init,
  input  logic        hold,
  input  logic [7:0]  data,
  output logic [31:0] crc_out
);

  logic [31:0] crc;

  // One byte through the reflected polynomial, LSB first
  function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] d);
    logic [31:0] r;
    r = c;
    for (int i = 0; i < 8; i++) begin
      r = (r[0] ^ d[i]) ? ((r >> 1) ^ 32'hedb88320) : (r >> 1);
    end
    return r;
  endfunction

  always_ff @(posedge gmii_tx_clk) begin
    if (sys_rst || init) begin
      crc <= '1;                                        // Seed all ones
    end else if (!hold) begin
      crc <= crc_byte(crc, data);
    end
  end

  // Low byte of the inverted CRC goes on the wire first
  assign crc_out = ~{crc[7:0], crc[15:8], crc[23:16], crc[31:24]};

endmodule

`default_nettype wire

// File: logic/arp_reply_parser.sv
`timescale 1ns/1ps
`default_nettype none

module arp_reply_parser (
  input  logic                        gmii_tx_clk,
  input  logic                        sys_rst,
  input  traffic_gen_pkg::gmii_t      rx,
  input  traffic_gen_pkg::tx_config_t cfg,
  input  logic                        req_arp,
  output traffic_gen_pkg::mac_t       dst_mac,
  output logic                        arp_reply
);

  logic                  in_frame;                      // Past the SFD
  logic [5:0]            rx_cnt;                        // Saturates at 63
  logic [15:0]           rx_type;
  logic [15:0]           rx_opcode;
  traffic_gen_pkg::mac_t rx_sha;
  traffic_gen_pkg::ip4_t rx_spa;
  traffic_gen_pkg::ip4_t rx_tpa;
  logic                  match;

  function automatic logic in_field(input logic [5:0] idx, input int unsigned first,
                                    input int unsigned len);
    return (idx >= 6'(first)) && (idx < 6'(first + len));
  endfunction

  // --------------------------------------------------------------------------
  // Field capture, big endian shift-in
  // --------------------------------------------------------------------------
  always_ff @(posedge gmii_tx_clk) begin
    if (rx.en && in_frame) begin
      if (in_field(rx_cnt, traffic_gen_pkg::rx_off_type, 2))
        rx_type <= {rx_type[7:0], rx.data};
      if (in_field(rx_cnt, traffic_gen_pkg::rx_off_opcode, 2))
        rx_opcode <= {rx_opcode[7:0], rx.data};
      if (in_field(rx_cnt, traffic_gen_pkg::rx_off_sha, 6))
        rx_sha <= {rx_sha[39:0], rx.data};
      if (in_field(rx_cnt, traffic_gen_pkg::rx_off_spa, 4))
        rx_spa <= {rx_spa[23:0], rx.data};
      if (in_field(rx_cnt, traffic_gen_pkg::rx_off_tpa, 4))
        rx_tpa <= {rx_tpa[23:0], rx.data};
    end
  end

  assign match = (rx_type == traffic_gen_pkg::ethertype_arp) &&
                 (rx_opcode == traffic_gen_pkg::arp_op_reply) &&
                 (rx_spa == cfg.gw_ip) && (rx_tpa == cfg.src_ip) &&
                 !rx_sha[40] && !req_arp;               // Group bit clear

  // --------------------------------------------------------------------------
  // Frame tracking and MAC latch
  // --------------------------------------------------------------------------
  always_ff @(posedge gmii_tx_clk) begin
    if (sys_rst) begin
      in_frame  <= 1'b0;
      rx_cnt    <= '0;
      dst_mac   <= '0;
      arp_reply <= 1'b0;
    end else begin
      arp_reply <= 1'b0;
      if (!rx.en) begin
        in_frame <= 1'b0;
      end else if (!in_frame) begin
        if (rx.data == traffic_gen_pkg::sfd_byte) begin
          in_frame <= 1'b1;                             // Next byte is offset 0
          rx_cnt   <= '0;
        end
      end else begin
        if (rx_cnt != '1)
          rx_cnt <= rx_cnt + 6'd1;
        if (rx_cnt == 6'(traffic_gen_pkg::rx_off_end) && match) begin
          dst_mac   <= rx_sha;
          arp_reply <= 1'b1;
        end
      end
      if (req_arp)
        dst_mac <= '0;                                  // Force a new resolution
    end
  end

endmodule

`default_nettype wire

// File: logic/frame_tx_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module frame_tx_fsm #(
  parameter int unsigned arp_timeout = 65535
) (
  input  logic                        gmii_tx_clk,
  input  logic                        sys_rst,
  input  traffic_gen_pkg::tx_config_t cfg,
  input  traffic_gen_pkg::mac_t       dst_mac,
  input  logic                        arp_reply,
  input  logic [31:0]                 crc_out,
  output traffic_gen_pkg::gmii_t      tx,
  output logic                        crc_init,
  output logic                        crc_hold,
  output logic [7:0]                  crc_data,
  output logic                        frame_start
);

  traffic_gen_pkg::tx_state_e state;
  logic [15:0]  cnt;                                    // Wire byte, preamble included
  logic [31:0]  gap_cnt;
  logic [31:0]  wait_cnt;
  logic [15:0]  ident;
  logic [19:0]  hdr_sum;
  logic [19:0]  ip_sum;
  logic [15:0]  ip_csum;
  logic [15:0]  cur_len;                                // Dest MAC through FCS
  logic [15:0]  wire_len;
  logic [15:0]  off;
  logic [15:0]  fcs_idx;
  logic [15:0]  ip_len;
  logic [15:0]  udp_len;
  logic [335:0] arp_hdr;
  logic [375:0] v4_hdr;
  logic [375:0] hdr;
  logic         start;
  logic         active;
  logic [7:0]   next_byte;

  // --------------------------------------------------------------------------
  // Frame contents
  // --------------------------------------------------------------------------
  assign cur_len  = (state == traffic_gen_pkg::send_v4) ? cfg.frame_len
                                                         : 16'(traffic_gen_pkg::arp_frame_len);
  assign wire_len = cur_len + 16'(traffic_gen_pkg::preamble_len);
  assign off      = cnt - 16'(traffic_gen_pkg::preamble_len);
  assign fcs_idx  = off - (cur_len - 16'(traffic_gen_pkg::fcs_len));
  assign ip_len   = cfg.frame_len - 16'(traffic_gen_pkg::ip_hdr_overhead);
  assign udp_len  = cfg.frame_len - 16'(traffic_gen_pkg::udp_overhead);

  assign arp_hdr = {48'hffff_ffff_ffff, cfg.src_mac, traffic_gen_pkg::ethertype_arp,
                    16'h0001, traffic_gen_pkg::ethertype_ipv4,  // HW Ethernet, proto IPv4
                    8'd6, 8'd4, traffic_gen_pkg::arp_op_request,
                    cfg.src_mac, cfg.src_ip, 48'h0, cfg.gw_ip};

  assign v4_hdr = {dst_mac, cfg.src_mac, traffic_gen_pkg::ethertype_ipv4,
                   8'h45, 8'h00, ip_len, ident, 16'h0000,       // No fragmentation
                   traffic_gen_pkg::ipv4_ttl, 8'h11, ip_csum,   // Protocol UDP
                   cfg.src_ip, cfg.dst_ip,
                   traffic_gen_pkg::udp_port, traffic_gen_pkg::udp_port, udp_len, 16'h0000,
                   traffic_gen_pkg::magic_code};

  // ARP padding is zero, so both share one lookup width
  assign hdr = (state == traffic_gen_pkg::send_v4) ? v4_hdr : {arp_hdr, 40'h0};

  assign hdr_sum = 20'h04500 + 20'(ip_len) + 20'(ident) +
                   20'({traffic_gen_pkg::ipv4_ttl, 8'h11}) +
                   20'(cfg.src_ip[31:16]) + 20'(cfg.src_ip[15:0]) +
                   20'(cfg.dst_ip[31:16]) + 20'(cfg.dst_ip[15:0]);

  // Checksum settles during the preamble
  always_ff @(posedge gmii_tx_clk) begin
    case (cnt)
      16'd1: ip_sum <= hdr_sum;
      16'd2: ip_sum <= 20'(ip_sum[15:0]) + 20'(ip_sum[19:16]);
      16'd3: ip_csum <= ~(ip_sum[15:0] + 16'(ip_sum[16]));      // Last carry
      default: ;
    endcase
  end

  always_comb begin
    if (cnt < 16'(traffic_gen_pkg::preamble_len - 1))
      next_byte = traffic_gen_pkg::preamble_byte;
    else if (cnt == 16'(traffic_gen_pkg::preamble_len - 1))
      next_byte = traffic_gen_pkg::sfd_byte;
    else if (off >= cur_len - 16'(traffic_gen_pkg::fcs_len))
      next_byte = crc_out[31 - 8 * fcs_idx[1:0] -: 8];
    else if (off < 16'($bits(hdr) / 8))
      next_byte = hdr[$bits(hdr) - 1 - 8 * off -: 8];
    else
      next_byte = 8'h00;                                // Payload tail
  end

  assign start  = (state == traffic_gen_pkg::send_v4) && (cnt == '0) &&
                  (dst_mac != '0) && cfg.enable;
  assign active = ((state == traffic_gen_pkg::req_arp) ||
                   ((state == traffic_gen_pkg::send_v4) && (cnt != '0 || start))) &&
                  (cnt < wire_len);

  assign crc_init = (cnt < 16'(traffic_gen_pkg::preamble_len));
  assign crc_hold = !crc_init && (off >= cur_len - 16'(traffic_gen_pkg::fcs_len));
  assign crc_data = next_byte;

  // --------------------------------------------------------------------------
  // State machine
  // --------------------------------------------------------------------------
  always_ff @(posedge gmii_tx_clk) begin
    if (sys_rst) begin
      state       <= traffic_gen_pkg::req_arp;
      cnt         <= '0;
      gap_cnt     <= '0;
      wait_cnt    <= '0;
      ident       <= '0;
      tx          <= '0;
      frame_start <= 1'b0;
    end else begin
      tx.en       <= active;
      tx.data     <= active ? next_byte : 8'h00;
      frame_start <= start;
      case (state)
        traffic_gen_pkg::req_arp: begin
          if (cnt == wire_len) begin
            cnt      <= '0;
            wait_cnt <= 32'(arp_timeout - 1);
            state    <= traffic_gen_pkg::wait_arp;
          end else begin
            cnt <= cnt + 16'd1;
          end
        end
        traffic_gen_pkg::wait_arp: begin
          wait_cnt <= wait_cnt - 32'd1;
          if (arp_reply || dst_mac != '0)                // Reply may land mid request
            state <= traffic_gen_pkg::send_v4;
          else if (wait_cnt == '0)
            state <= traffic_gen_pkg::req_arp;
        end
        traffic_gen_pkg::send_v4: begin
          if (cnt == wire_len) begin
            cnt   <= '0;
            ident <= ident + 16'd1;
            // End cycle and restart cycle add two idle cycles
            gap_cnt <= (cfg.gap > 32'(traffic_gen_pkg::min_gap)) ? cfg.gap - 32'd2
                                                                  : 32'(traffic_gen_pkg::min_gap) - 32'd2;
            state   <= traffic_gen_pkg::gap;
          end else if (cnt != '0 || start) begin
            cnt <= cnt + 16'd1;
          end else if (dst_mac == '0) begin
            state <= traffic_gen_pkg::req_arp;          // MAC dropped while idle
          end
        end
        traffic_gen_pkg::gap: begin
          gap_cnt <= gap_cnt - 32'd1;
          if (gap_cnt == '0)
            state <= (dst_mac != '0) ? traffic_gen_pkg::send_v4 : traffic_gen_pkg::req_arp;
        end
        default: state <= traffic_gen_pkg::req_arp;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/rate_meter.sv
`timescale 1ns/1ps
`default_nettype none

module rate_meter #(
  parameter int unsigned sec_ticks = 125000000
) (
  input  logic        gmii_tx_clk,
  input  logic        sys_rst,
  input  logic        frame_start,
  input  logic [15:0] frame_bytes,
  output logic [31:0] pps,
  output logic [31:0] throughput
);

  logic [31:0] sec_cnt;
  logic [31:0] pkt_cnt;
  logic [31:0] byte_cnt;
  logic        tick;

  assign tick = (sec_cnt == '0);                        // Once per second

  always_ff @(posedge gmii_tx_clk) begin
    if (sys_rst) begin
      sec_cnt    <= 32'(sec_ticks - 1);
      pkt_cnt    <= '0;
      byte_cnt   <= '0;
      pps        <= '0;
      throughput <= '0;
    end else if (tick) begin
      sec_cnt    <= 32'(sec_ticks - 1);
      pps        <= pkt_cnt;
      throughput <= byte_cnt;
      pkt_cnt    <= {31'd0, frame_start};               // Start on tick opens new interval
      byte_cnt   <= frame_start ? {16'd0, frame_bytes} : 32'd0;
    end else begin
      sec_cnt <= sec_cnt - 32'd1;
      if (frame_start) begin
        pkt_cnt  <= pkt_cnt + 32'd1;
        byte_cnt <= byte_cnt + {16'd0, frame_bytes};
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/traffic_gen_top.sv
`timescale 1ns/1ps
`default_nettype none

module traffic_gen_top #(
  parameter int unsigned sec_ticks   = 125000000,
  parameter int unsigned arp_timeout = 65535
) (
  input  logic                        gmii_tx_clk,
  input  logic                        sys_rst,
  input  traffic_gen_pkg::gmii_t      rx,
  input  traffic_gen_pkg::tx_config_t cfg,
  input  logic                        req_arp,
  output traffic_gen_pkg::gmii_t      tx,
  output traffic_gen_pkg::mac_t       dst_mac,
  output logic [31:0]                 pps,
  output logic [31:0]                 throughput
);

  logic        crc_init;
  logic        crc_hold;
  logic [7:0]  crc_data;
  logic [31:0] crc_out;
  logic        arp_reply;
  logic        frame_start;

  // --------------------------------------------------------------------------
  // FCS, ARP learning, transmit and metering
  // --------------------------------------------------------------------------
  crc32_gen u_crc (
    .gmii_tx_clk (gmii_tx_clk),
    .sys_rst     (sys_rst),
    .init        (crc_init),
    .hold        (crc_hold),
    .data        (crc_data),
    .crc_out     (crc_out)
  );

  arp_reply_parser u_parser (
    .gmii_tx_clk (gmii_tx_clk),
    .sys_rst     (sys_rst),
    .rx          (rx),
    .cfg         (cfg),
    .req_arp     (req_arp),
    .dst_mac     (dst_mac),
    .arp_reply   (arp_reply)
  );

  frame_tx_fsm #(
    .arp_timeout (arp_timeout)
  ) u_fsm (
    .gmii_tx_clk (gmii_tx_clk),
    .sys_rst     (sys_rst),
    .cfg         (cfg),
    .dst_mac     (dst_mac),
    .arp_reply   (arp_reply),
    .crc_out     (crc_out),
    .tx          (tx),
    .crc_init    (crc_init),
    .crc_hold    (crc_hold),
    .crc_data    (crc_data),
    .frame_start (frame_start)
  );

  rate_meter #(
    .sec_ticks   (sec_ticks)
  ) u_meter (
    .gmii_tx_clk (gmii_tx_clk),
    .sys_rst     (sys_rst),
    .frame_start (frame_start),
    .frame_bytes (cfg.frame_len),                       // Counted dest MAC through FCS
    .pps         (pps),
    .throughput  (throughput)
  );

endmodule

`default_nettype wire

// File: verification/traffic_gen_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module traffic_gen_assertions (
  input logic                       gmii_tx_clk,
  input logic                       sys_rst,
  input traffic_gen_pkg::gmii_t     tx,
  input traffic_gen_pkg::tx_state_e state
);

  // Transmit enable is cleared by reset
  assert property (@(posedge gmii_tx_clk) sys_rst |=> !tx.en)
    else $error("tx.en high after a reset cycle");

  // wait_arp follows only a request and gap only an IPv4 frame
  assert property (@(posedge gmii_tx_clk) disable iff (sys_rst)
                   !$isunknown(state) &&
                   (state != traffic_gen_pkg::wait_arp ||
                    $past(state) inside {traffic_gen_pkg::req_arp, traffic_gen_pkg::wait_arp}) &&
                   (state != traffic_gen_pkg::gap ||
                    $past(state) inside {traffic_gen_pkg::send_v4, traffic_gen_pkg::gap}))
    else $error("Transmit FSM state unknown or entered from an illegal state");

  // No frame bytes while the inter-frame gap runs
  assert property (@(posedge gmii_tx_clk) disable iff (sys_rst)
                   (state == traffic_gen_pkg::gap) |-> !tx.en)
    else $error("tx.en high in the gap state");

endmodule

bind frame_tx_fsm traffic_gen_assertions u_assert (
  .gmii_tx_clk (gmii_tx_clk),
  .sys_rst     (sys_rst),
  .tx          (tx),
  .state       (state)
);

`default_nettype wire

// File: verification/tb_traffic_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_traffic_gen;

  localparam int unsigned sec_ticks   = 4000;
  localparam int unsigned arp_timeout = 400;
  localparam int unsigned wait_limit  = 2000;           // Cycles per wait loop

  logic                        gmii_tx_clk;
  logic                        sys_rst;
  traffic_gen_pkg::gmii_t      rx;
  traffic_gen_pkg::tx_config_t cfg;
  logic                        req_arp;
  traffic_gen_pkg::gmii_t      tx;
  traffic_gen_pkg::mac_t       dst_mac;
  logic [31:0]                 pps;
  logic [31:0]                 throughput;

  logic [31:0]           lfsr;
  logic [7:0]            frame_q[$];                    // Captured wire bytes
  int                    idle;                          // Low cycles before the frame
  traffic_gen_pkg::mac_t gw_mac;
  logic [15:0]           ident_exp;
  logic [31:0]           edges;
  logic                  prev_en;
  logic                  rising;
  int                    rise_cnt;
  int                    exp_pps;
  int                    tick_count;
  logic                  clean;                         // Interval saw a learned MAC only
  logic                  exp_clean;

  traffic_gen_top #(
    .sec_ticks   (sec_ticks),
    .arp_timeout (arp_timeout)
  ) uut (
    .gmii_tx_clk (gmii_tx_clk),
    .sys_rst     (sys_rst),
    .rx          (rx),
    .cfg         (cfg),
    .req_arp     (req_arp),
    .tx          (tx),
    .dst_mac     (dst_mac),
    .pps         (pps),
    .throughput  (throughput)
  );

  always #10 gmii_tx_clk = ~gmii_tx_clk;

  // --------------------------------------------------------------------------
  // Frame start counting against the one second tick
  // --------------------------------------------------------------------------
  assign rising = tx.en && !prev_en;

  always @(posedge gmii_tx_clk) edges <= sys_rst ? 32'd0 : edges + 32'd1;

  always @(negedge gmii_tx_clk) begin
    prev_en <= tx.en;
    if (sys_rst) begin
      rise_cnt   <= 0;
      clean      <= 1'b1;
      tick_count <= 0;
      exp_pps    <= 0;
      exp_clean  <= 1'b0;
    end else if ((edges + 32'd1) % sec_ticks == 0) begin  // Next edge is a tick
      exp_pps    <= rise_cnt;
      exp_clean  <= clean && (dst_mac != '0);
      tick_count <= tick_count + 1;
      rise_cnt   <= int'(rising);
      clean      <= (dst_mac != '0);
    end else begin
      rise_cnt <= rise_cnt + int'(rising);
      clean    <= clean && (dst_mac != '0);
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};     // Taps 32 22 2 1
  endfunction

  task automatic rand_bits(input int n, output logic [47:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[46:0], lfsr[0]};
    end
  endtask

  task automatic stop_failed();
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
      stop_failed();
    end
  endtask

  task automatic capture_frame();
    frame_q.delete();
    idle = 0;
    @(negedge gmii_tx_clk);
    while (!tx.en) begin
      idle++;
      if (idle > wait_limit) begin
        $display("Timed out waiting for a frame on tx");
        stop_failed();
      end
      @(negedge gmii_tx_clk);
    end
    while (tx.en) begin
      frame_q.push_back(tx.data);
      if (frame_q.size() > wait_limit) begin
        $display("Frame on tx never ended");
        stop_failed();
      end
      @(negedge gmii_tx_clk);
    end
  endtask

  // Big endian field, offset counted from the dest MAC
  function automatic logic [63:0] field(input int off, input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[55:0], frame_q[8 + off + i]};
    return v;
  endfunction

  function automatic logic [31:0] fcs_calc(input int n);
    logic [31:0] c;
    c = '1;
    for (int i = 0; i < n; i++) begin
      c = c ^ {24'd0, frame_q[8 + i]};
      for (int b = 0; b < 8; b++)
        c = c[0] ? ((c >> 1) ^ 32'hedb88320) : (c >> 1);
    end
    return ~c;
  endfunction

  task automatic check_framing(input int len);
    logic [31:0] c;
    check_value(frame_q.size(), len + 8, "wire length");
    for (int i = 0; i < 7; i++)
      check_value(frame_q[i], 8'h55, "preamble byte");
    check_value(frame_q[7], 8'hd5, "SFD");
    c = fcs_calc(len - 4);
    check_value(field(len - 4, 4), {c[7:0], c[15:8], c[23:16], c[31:24]}, "FCS");
  endtask

  task automatic check_arp_request();
    check_framing(64);
    check_value(field(0, 6), 48'hffff_ffff_ffff, "ARP dest MAC");
    check_value(field(6, 6), cfg.src_mac, "ARP source MAC");
    check_value(field(12, 2), 16'h0806, "ARP ethertype");
    check_value(field(14, 8), 64'h0001_0800_0604_0001, "ARP hw, proto, sizes, opcode");
    check_value(field(22, 6), cfg.src_mac, "ARP sender MAC");
    check_value(field(28, 4), cfg.src_ip, "ARP sender IP");
    check_value(field(32, 6), 48'h0, "ARP target MAC");
    check_value(field(38, 4), cfg.gw_ip, "ARP target IP");
    for (int i = 42; i < 60; i++)
      check_value(field(i, 1), 8'h00, "ARP padding");
  endtask

  task automatic check_v4_frame();
    logic [31:0] sum;
    int          len;
    len = cfg.frame_len;
    sum = '0;
    check_framing(len);
    check_value(field(0, 6), gw_mac, "IPv4 dest MAC");
    check_value(field(6, 6), cfg.src_mac, "IPv4 source MAC");
    check_value(field(12, 4), 32'h0800_4500, "ethertype, version, TOS");
    check_value(field(16, 2), len - 18, "IP total length");
    check_value(field(18, 2), ident_exp, "IP identification");
    check_value(field(20, 4), 32'h0000_4011, "flags, TTL, protocol");
    check_value(field(26, 8), {cfg.src_ip, cfg.dst_ip}, "IP addresses");
    for (int w = 0; w < 10; w++)
      sum = sum + 32'(field(14 + 2 * w, 2));
    sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};
    sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};
    check_value(sum[15:0], 16'hffff, "IP header checksum sum");
    check_value(field(34, 4), {16'd3422, 16'd3422}, "UDP ports");
    check_value(field(38, 4), {16'(len - 38), 16'h0000}, "UDP length and checksum");
    check_value(field(42, 5), 40'hcc00cc00cc, "magic code");
    for (int i = 47; i < len - 4; i++)
      check_value(field(i, 1), 8'h00, "payload tail");
    ident_exp = ident_exp + 16'd1;
  endtask

  task automatic capture_v4();
    for (int i = 0; i < 4; i++) begin
      capture_frame();
      if (frame_q.size() > 22 && field(12, 2) == 16'h0800)
        return;
    end
    $display("No IPv4 frame seen after the ARP reply");
    stop_failed();
  endtask

  task automatic send_reply(input traffic_gen_pkg::mac_t sha, input traffic_gen_pkg::ip4_t spa,
                            input traffic_gen_pkg::ip4_t tpa);
    logic [7:0]   q[$];
    logic [335:0] body;
    body = {cfg.src_mac, sha, 16'h0806, 16'h0001, 16'h0800, 8'd6, 8'd4, 16'h0002,
            sha, spa, cfg.src_mac, tpa};
    repeat (7) q.push_back(8'h55);
    q.push_back(8'hd5);
    for (int i = 0; i < 42; i++)
      q.push_back(body[335 - 8 * i -: 8]);
    repeat (22) q.push_back(8'h00);                     // Padding and a dummy FCS
    foreach (q[i]) begin
      @(posedge gmii_tx_clk);
      rx.data <= q[i];
      rx.en   <= 1'b1;
    end
    @(posedge gmii_tx_clk);
    rx.data <= 8'h00;
    rx.en   <= 1'b0;
    repeat (3) @(posedge gmii_tx_clk);
    @(negedge gmii_tx_clk);
  endtask

  // --------------------------------------------------------------------------
  // Directed tests
  // --------------------------------------------------------------------------
  task automatic test_first_arp();
    capture_frame();
    check_value(idle <= 2, 1, "first ARP start delay");
    check_arp_request();
  endtask

  task automatic test_arp_retry();
    capture_frame();
    check_value(idle + 1 >= arp_timeout, 1, "idle cycles before ARP retry");
    check_arp_request();
  endtask

  task automatic test_arp_reply();
    send_reply(gw_mac, cfg.gw_ip, cfg.src_ip ^ 32'h1);
    check_value(dst_mac, 48'h0, "dst_mac after wrong target IP");
    send_reply(gw_mac | 48'h0100_0000_0000, cfg.gw_ip, cfg.src_ip);
    check_value(dst_mac, 48'h0, "dst_mac after multicast sender");
    send_reply(gw_mac, cfg.gw_ip, cfg.src_ip);
    check_value(dst_mac, gw_mac, "dst_mac after matching reply");
  endtask

  task automatic test_v4_stream();
    check_value(tx.en, 1'b0, "tx.en while cfg.enable is low");
    @(posedge gmii_tx_clk);
    cfg.enable <= 1'b1;
    capture_v4();
    check_v4_frame();
    repeat (4) begin
      capture_frame();
      check_value(idle + 1 >= cfg.gap, 1, "inter-frame gap");
      check_v4_frame();
    end
  endtask

  task automatic test_rate();
    int t;
    int n;
    t = 0;
    n = tick_count;
    forever begin
      @(negedge gmii_tx_clk);
      t++;
      if (tick_count != n) begin
        n = tick_count;
        if (exp_clean && n >= 2)
          break;
      end
      if (t > 3 * sec_ticks) begin
        $display("Timed out waiting for a clean one second interval");
        stop_failed();
      end
    end
    check_value(exp_pps != 0, 1, "frames in the interval");
    check_value(pps, exp_pps, "pps");
    check_value(throughput, exp_pps * cfg.frame_len, "throughput");
  endtask

  task automatic test_req_arp();
    int t;
    t = 0;
    @(posedge gmii_tx_clk);
    req_arp <= 1'b1;
    @(posedge gmii_tx_clk);
    req_arp <= 1'b0;
    @(negedge gmii_tx_clk);
    check_value(dst_mac, 48'h0, "dst_mac after req_arp");
    while (tx.en) begin                                 // Let the current frame finish
      t++;
      if (t > wait_limit) begin
        $display("Frame in flight never ended after req_arp");
        stop_failed();
      end
      @(negedge gmii_tx_clk);
    end
    capture_frame();
    check_arp_request();
  endtask

  initial begin
    logic [47:0] r;
    gmii_tx_clk = 1'b0;
    sys_rst     = 1'b1;
    rx          = '0;
    req_arp     = 1'b0;
    prev_en     = 1'b0;
    edges       = '0;
    ident_exp   = '0;
    lfsr        = 32'h6f4;
    rand_bits(48, r);
    cfg.src_mac   = r & ~48'h0100_0000_0000;            // Unicast
    rand_bits(32, r);
    cfg.src_ip    = r[31:0];
    rand_bits(32, r);
    cfg.gw_ip     = r[31:0];
    rand_bits(32, r);
    cfg.dst_ip    = r[31:0];
    rand_bits(48, r);
    gw_mac        = (r & ~48'h0100_0000_0000) | 48'h2;
    cfg.enable    = 1'b0;                               // IPv4 stream held off at first
    cfg.frame_len = 16'd100;
    cfg.gap       = 32'd12;
    repeat (16) @(posedge gmii_tx_clk);
    sys_rst <= 1'b0;
    test_first_arp();
    test_arp_retry();
    test_arp_reply();
    test_v4_stream();
    test_rate();
    test_req_arp();
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
logic/traffic_gen_pkg.sv
logic/crc32_gen.sv
logic/arp_reply_parser.sv
logic/frame_tx_fsm.sv
logic/rate_meter.sv
logic/traffic_gen_top.sv
verification/traffic_gen_assertions.sv
verification/tb_traffic_gen.sv
